/* design/amber_pkg.sv */
`default_nettype none

package amber_pkg;

    // ----------------------------------------
    // Widths and base types
    // ----------------------------------------
    localparam int ADDR_W = 48;
    localparam int DATA_W = 24;
    localparam int TGT_W  = 18;
    localparam int IMM_W  = 10;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [7:0]        csr_idx_t;

    // ----------------------------------------
    // Opcodes
    // ----------------------------------------
    // Codes outside this list retire as no-ops
    typedef enum logic [5:0] {
        OPC_NOP     = 6'h00,
        OPC_JUMP    = 6'h24,
        OPC_CSRWR   = 6'h38,
        OPC_CSRRD   = 6'h39,
        OPC_SYSCALL = 6'h3c,
        OPC_KRET    = 6'h3d
    } opcode_e;

    // ----------------------------------------
    // Instruction formats
    // ----------------------------------------
    typedef struct packed {
        opcode_e          opcode;
        csr_idx_t         csr_idx;
        logic [IMM_W-1:0] imm10;
    } csr_fmt_t;

    typedef struct packed {
        opcode_e          opcode;
        logic [TGT_W-1:0] target;
    } jump_fmt_t;

    // One word, read as CSR access or as jump depending on opcode
    typedef union packed {
        csr_fmt_t  csr;
        jump_fmt_t jmp;
    } instr_u;

    // ----------------------------------------
    // CSR map
    // ----------------------------------------
    localparam csr_idx_t CSR_STATUS      = 8'h00;
    localparam csr_idx_t CSR_PCC_BASE_LO = 8'h20;
    localparam csr_idx_t CSR_PCC_BASE_HI = 8'h21;
    localparam csr_idx_t CSR_PCC_LEN_LO  = 8'h22;
    localparam csr_idx_t CSR_PCC_LEN_HI  = 8'h23;
    localparam csr_idx_t CSR_PCC_CUR_LO  = 8'h24;
    localparam csr_idx_t CSR_PCC_CUR_HI  = 8'h25;
    localparam csr_idx_t CSR_PCC_PERMS   = 8'h26;
    localparam csr_idx_t CSR_PCC_ATTR    = 8'h27;
    localparam csr_idx_t CSR_PCC_TAG     = 8'h28;

    // Execute permission in PERMS
    localparam int PERM_X_BIT = 2;

endpackage

`default_nettype wire

/* design/fetch_gate.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_gate (
    input  wire                      iw_clk,
    input  wire                      iw_rst,
    input  wire                      redirect,
    input  wire amber_pkg::addr_t    redirect_pc,
    input  wire amber_pkg::addr_t    pcc_base,
    input  wire amber_pkg::addr_t    pcc_len,
    input  wire                      pcc_exec,
    output amber_pkg::addr_t         fetch_pc,
    output logic                     fetch_valid
);

    amber_pkg::addr_t win_end;
    logic             above_base;
    logic             below_end;

    // ----------------------------------------
    // Capability bounds
    // ----------------------------------------
    // End of window wraps at 48 bits
    assign win_end    = pcc_base + pcc_len;
    assign above_base = (fetch_pc >= pcc_base);
    assign below_end  = (fetch_pc < win_end);

    // Tag is already folded into pcc_exec
    assign fetch_valid = above_base && below_end && pcc_exec;

    // ----------------------------------------
    // Program counter
    // ----------------------------------------
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            fetch_pc <= '0;
        end else if (redirect) begin
            fetch_pc <= redirect_pc;
        end else if (fetch_valid) begin
            fetch_pc <= fetch_pc + amber_pkg::addr_t'(1);
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Outside the window the PC only moves on a redirect
    a_pc_hold: assert property (
        @(posedge iw_clk) disable iff (iw_rst)
        (!redirect && !fetch_valid) |=> $stable(fetch_pc)
    );

endmodule

`default_nettype wire

/* design/instr_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decode #(
    parameter logic [amber_pkg::TGT_W-1:0] TRAP_VECTOR = 18'd256
) (
    input  wire                      iw_clk,
    input  wire                      iw_rst,
    input  wire                      instr_valid,
    input  wire amber_pkg::instr_u   instr,
    output logic                     ret_valid,
    output amber_pkg::opcode_e       ret_op,
    output amber_pkg::csr_idx_t      ret_csr_idx,
    output amber_pkg::data_t         ret_imm,
    output logic                     redirect,
    output amber_pkg::addr_t         redirect_pc
);

    localparam int ADDR_PAD = amber_pkg::ADDR_W - amber_pkg::TGT_W;
    localparam int DATA_PAD = amber_pkg::DATA_W - amber_pkg::IMM_W;

    logic              dec_valid;
    amber_pkg::instr_u dec_instr;
    logic              is_jump;
    logic              is_syscall;
    logic              is_kret;

    // ----------------------------------------
    // Decode register
    // ----------------------------------------
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
        end
    end

    // Word held only when a new instruction arrives
    always_ff @(posedge iw_clk) begin
        if (instr_valid) begin
            dec_instr <= instr;
        end
    end

    // ----------------------------------------
    // Field split
    // ----------------------------------------
    // CSR view
    assign ret_valid   = dec_valid;
    assign ret_op      = dec_instr.csr.opcode;
    assign ret_csr_idx = dec_instr.csr.csr_idx;
    assign ret_imm     = {{DATA_PAD{1'b0}}, dec_instr.csr.imm10};

    // Control transfer ops
    assign is_jump    = (dec_instr.jmp.opcode == amber_pkg::OPC_JUMP);
    assign is_syscall = (dec_instr.jmp.opcode == amber_pkg::OPC_SYSCALL);
    assign is_kret    = (dec_instr.jmp.opcode == amber_pkg::OPC_KRET);

    assign redirect = dec_valid && (is_jump || is_syscall || is_kret);

    // SYSCALL ignores its target field
    always_comb begin
        if (is_syscall) begin
            redirect_pc = {{ADDR_PAD{1'b0}}, TRAP_VECTOR};
        end else begin
            redirect_pc = {{ADDR_PAD{1'b0}}, dec_instr.jmp.target};
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_ret_valid_known: assert property (
        @(posedge iw_clk) disable iff (iw_rst)
        !$isunknown(ret_valid)
    );

endmodule

`default_nettype wire

/* design/pcc_csr_window.sv */
`timescale 1ns/10ps
`default_nettype none

module pcc_csr_window #(
    parameter amber_pkg::addr_t PCC_RESET_LEN = 48'd4096
) (
    input  wire                        iw_clk,
    input  wire                        iw_rst,
    input  wire                        ret_valid,
    input  wire amber_pkg::opcode_e    ret_op,
    input  wire amber_pkg::csr_idx_t   ret_csr_idx,
    input  wire amber_pkg::data_t      ret_imm,
    input  wire amber_pkg::addr_t      fetch_pc,
    output amber_pkg::addr_t           pcc_base,
    output amber_pkg::addr_t           pcc_len,
    output logic                       pcc_exec,
    output logic                       kernel_mode,
    output logic                       csr_rd_valid,
    output amber_pkg::data_t           csr_rd_data
);

    localparam int DW = amber_pkg::DATA_W;
    localparam int AW = amber_pkg::ADDR_W;

    // Only X granted out of reset
    localparam amber_pkg::data_t PERMS_RESET = amber_pkg::data_t'(1) << amber_pkg::PERM_X_BIT;

    amber_pkg::data_t pcc_perms;
    amber_pkg::data_t pcc_attr;
    logic             pcc_tag;
    logic             csr_wr;
    logic             csr_rd;
    amber_pkg::data_t rd_mux;

    // Writes need kernel mode at retire
    assign csr_wr = ret_valid && (ret_op == amber_pkg::OPC_CSRWR) && kernel_mode;
    assign csr_rd = ret_valid && (ret_op == amber_pkg::OPC_CSRRD);

    // ----------------------------------------
    // PCC window registers
    // ----------------------------------------
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pcc_base  <= '0;
            pcc_len   <= PCC_RESET_LEN;
            pcc_perms <= PERMS_RESET;
            pcc_attr  <= '0;
            pcc_tag   <= 1'b1;
        end else if (csr_wr) begin
            case (ret_csr_idx)
                amber_pkg::CSR_PCC_BASE_LO: pcc_base[DW-1:0]  <= ret_imm;
                amber_pkg::CSR_PCC_BASE_HI: pcc_base[AW-1:DW] <= ret_imm;
                amber_pkg::CSR_PCC_LEN_LO:  pcc_len[DW-1:0]   <= ret_imm;
                amber_pkg::CSR_PCC_LEN_HI:  pcc_len[AW-1:DW]  <= ret_imm;
                amber_pkg::CSR_PCC_PERMS:   pcc_perms         <= ret_imm;
                amber_pkg::CSR_PCC_ATTR:    pcc_attr          <= ret_imm;
                amber_pkg::CSR_PCC_TAG:     pcc_tag           <= ret_imm[0];
                default: ;
            endcase
        end
    end

    assign pcc_exec = pcc_perms[amber_pkg::PERM_X_BIT] & pcc_tag;

    // ----------------------------------------
    // Mode, 1 is kernel
    // ----------------------------------------
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            kernel_mode <= 1'b1;
        end else if (ret_valid) begin
            if (ret_op == amber_pkg::OPC_SYSCALL) begin
                kernel_mode <= 1'b1;
            end else if (ret_op == amber_pkg::OPC_KRET) begin
                kernel_mode <= 1'b0;
            end else if (csr_wr && (ret_csr_idx == amber_pkg::CSR_STATUS)) begin
                kernel_mode <= ret_imm[0];
            end
        end
    end

    // ----------------------------------------
    // CSR read path
    // ----------------------------------------
    // Live mode and live PC, the rest from storage
    always_comb begin
        rd_mux = '0;
        case (ret_csr_idx)
            amber_pkg::CSR_STATUS:      rd_mux[0] = kernel_mode;
            amber_pkg::CSR_PCC_BASE_LO: rd_mux    = pcc_base[DW-1:0];
            amber_pkg::CSR_PCC_BASE_HI: rd_mux    = pcc_base[AW-1:DW];
            amber_pkg::CSR_PCC_LEN_LO:  rd_mux    = pcc_len[DW-1:0];
            amber_pkg::CSR_PCC_LEN_HI:  rd_mux    = pcc_len[AW-1:DW];
            amber_pkg::CSR_PCC_CUR_LO:  rd_mux    = fetch_pc[DW-1:0];
            amber_pkg::CSR_PCC_CUR_HI:  rd_mux    = fetch_pc[AW-1:DW];
            amber_pkg::CSR_PCC_PERMS:   rd_mux    = pcc_perms;
            amber_pkg::CSR_PCC_ATTR:    rd_mux    = pcc_attr;
            amber_pkg::CSR_PCC_TAG:     rd_mux[0] = pcc_tag;
            default:                    rd_mux    = '0;
        endcase
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            csr_rd_valid <= 1'b0;
        end else begin
            csr_rd_valid <= csr_rd;
        end
    end

    always_ff @(posedge iw_clk) begin
        if (csr_rd) begin
            csr_rd_data <= rd_mux;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_rd_after_retire: assert property (
        @(posedge iw_clk) disable iff (iw_rst)
        csr_rd_valid |-> $past(ret_valid && (ret_op == amber_pkg::OPC_CSRRD))
    );

endmodule

`default_nettype wire

/* design/amber_core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module amber_core_top #(
    parameter amber_pkg::addr_t              PCC_RESET_LEN = 48'd4096,
    parameter logic [amber_pkg::TGT_W-1:0]   TRAP_VECTOR   = 18'd256
) (
    input  wire                      iw_clk,
    input  wire                      iw_rst,
    input  wire                      instr_valid,
    input  wire amber_pkg::instr_u   instr,
    output amber_pkg::addr_t         fetch_pc,
    output logic                     fetch_valid,
    output logic                     csr_rd_valid,
    output amber_pkg::data_t         csr_rd_data,
    output logic                     kernel_mode
);

    // Decode to retire and fetch
    logic                ret_valid;
    amber_pkg::opcode_e  ret_op;
    amber_pkg::csr_idx_t ret_csr_idx;
    amber_pkg::data_t    ret_imm;
    logic                redirect;
    amber_pkg::addr_t    redirect_pc;

    // PCC window to fetch
    amber_pkg::addr_t    pcc_base;
    amber_pkg::addr_t    pcc_len;
    logic                pcc_exec;

    instr_decode #(
        .TRAP_VECTOR (TRAP_VECTOR)
    ) u_decode (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ret_valid   (ret_valid),
        .ret_op      (ret_op),
        .ret_csr_idx (ret_csr_idx),
        .ret_imm     (ret_imm),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    pcc_csr_window #(
        .PCC_RESET_LEN (PCC_RESET_LEN)
    ) u_window (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .ret_valid    (ret_valid),
        .ret_op       (ret_op),
        .ret_csr_idx  (ret_csr_idx),
        .ret_imm      (ret_imm),
        .fetch_pc     (fetch_pc),
        .pcc_base     (pcc_base),
        .pcc_len      (pcc_len),
        .pcc_exec     (pcc_exec),
        .kernel_mode  (kernel_mode),
        .csr_rd_valid (csr_rd_valid),
        .csr_rd_data  (csr_rd_data)
    );

    fetch_gate u_fetch (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pcc_base    (pcc_base),
        .pcc_len     (pcc_len),
        .pcc_exec    (pcc_exec),
        .fetch_pc    (fetch_pc),
        .fetch_valid (fetch_valid)
    );

endmodule

`default_nettype wire

/* sim/amber_model.svh */
`ifndef AMBER_MODEL_SVH
`define AMBER_MODEL_SVH

// ----------------------------------------
// Reference state, advanced once per rising edge
// ----------------------------------------
logic [31:0]       lcg_state;
amber_pkg::addr_t  m_pc;
amber_pkg::addr_t  m_base;
amber_pkg::addr_t  m_len;
amber_pkg::data_t  m_perms;
amber_pkg::data_t  m_attr;
logic              m_tag;
logic              m_kernel;
logic              m_dec_valid;
amber_pkg::instr_u m_dec_instr;
logic              m_rd_valid;
amber_pkg::data_t  m_rd_data;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic logic model_fetch_ok();
    amber_pkg::addr_t lim;
    lim = m_base + m_len;
    return (m_pc >= m_base) && (m_pc < lim) && m_perms[amber_pkg::PERM_X_BIT] && m_tag;
endfunction

function automatic amber_pkg::data_t model_csr_value(input amber_pkg::csr_idx_t idx);
    case (idx)
        amber_pkg::CSR_STATUS:      return {23'd0, m_kernel};
        amber_pkg::CSR_PCC_BASE_LO: return m_base[23:0];
        amber_pkg::CSR_PCC_BASE_HI: return m_base[47:24];
        amber_pkg::CSR_PCC_LEN_LO:  return m_len[23:0];
        amber_pkg::CSR_PCC_LEN_HI:  return m_len[47:24];
        amber_pkg::CSR_PCC_CUR_LO:  return m_pc[23:0];
        amber_pkg::CSR_PCC_CUR_HI:  return m_pc[47:24];
        amber_pkg::CSR_PCC_PERMS:   return m_perms;
        amber_pkg::CSR_PCC_ATTR:    return m_attr;
        amber_pkg::CSR_PCC_TAG:     return {23'd0, m_tag};
        default:                    return '0;
    endcase
endfunction

// PCC_CUR is a mirror of the PC, writes to it vanish
task automatic model_csr_write(input amber_pkg::csr_idx_t idx, input amber_pkg::data_t v);
    case (idx)
        amber_pkg::CSR_STATUS:      m_kernel      = v[0];
        amber_pkg::CSR_PCC_BASE_LO: m_base[23:0]  = v;
        amber_pkg::CSR_PCC_BASE_HI: m_base[47:24] = v;
        amber_pkg::CSR_PCC_LEN_LO:  m_len[23:0]   = v;
        amber_pkg::CSR_PCC_LEN_HI:  m_len[47:24]  = v;
        amber_pkg::CSR_PCC_PERMS:   m_perms       = v;
        amber_pkg::CSR_PCC_ATTR:    m_attr        = v;
        amber_pkg::CSR_PCC_TAG:     m_tag         = v[0];
        default: ;
    endcase
endtask

task automatic model_reset();
    m_pc        = '0;
    m_base      = '0;
    m_len       = RESET_LEN;
    // X only
    m_perms     = 24'd4;
    m_attr      = '0;
    m_tag       = 1'b1;
    m_kernel    = 1'b1;
    m_dec_valid = 1'b0;
    m_dec_instr = '0;
    m_rd_valid  = 1'b0;
    m_rd_data   = '0;
endtask

// Retire the decoded word, then load the decode register
task automatic model_edge(input logic in_valid, input amber_pkg::instr_u in_instr);
    amber_pkg::instr_u w;
    logic              go;
    logic              step;
    w    = m_dec_instr;
    go   = m_dec_valid;
    step = model_fetch_ok();
    m_rd_valid = go && (w.csr.opcode == amber_pkg::OPC_CSRRD);
    if (m_rd_valid) begin
        m_rd_data = model_csr_value(w.csr.csr_idx);
    end
    if (go && (w.jmp.opcode == amber_pkg::OPC_SYSCALL)) begin
        m_pc     = {30'd0, TRAP_VEC};
        m_kernel = 1'b1;
    end else if (go && (w.jmp.opcode == amber_pkg::OPC_KRET)) begin
        m_pc     = {30'd0, w.jmp.target};
        m_kernel = 1'b0;
    end else if (go && (w.jmp.opcode == amber_pkg::OPC_JUMP)) begin
        m_pc = {30'd0, w.jmp.target};
    end else begin
        if (step) begin
            m_pc = m_pc + 48'd1;
        end
        if (go && m_kernel && (w.csr.opcode == amber_pkg::OPC_CSRWR)) begin
            model_csr_write(w.csr.csr_idx, {14'd0, w.csr.imm10});
        end
    end
    m_dec_valid = in_valid;
    if (in_valid) begin
        m_dec_instr = in_instr;
    end
endtask

`endif

/* sim/amber_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module amber_core_tb;

    localparam amber_pkg::addr_t RESET_LEN   = 48'd4096;
    localparam logic [17:0]      TRAP_VEC    = 18'd256;
    localparam int               RAND_CYCLES = 4000;

    logic              iw_clk;
    logic              iw_rst;
    logic              instr_valid;
    amber_pkg::instr_u instr;
    amber_pkg::addr_t  fetch_pc;
    logic              fetch_valid;
    logic              csr_rd_valid;
    amber_pkg::data_t  csr_rd_data;
    logic              kernel_mode;

    int n_reads;
    int n_stalls;
    int n_user;

    `include "amber_model.svh"

    amber_core_top #(
        .PCC_RESET_LEN (RESET_LEN),
        .TRAP_VECTOR   (TRAP_VEC)
    ) dut (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .fetch_pc     (fetch_pc),
        .fetch_valid  (fetch_valid),
        .csr_rd_valid (csr_rd_valid),
        .csr_rd_data  (csr_rd_data),
        .kernel_mode  (kernel_mode)
    );

    initial begin
        iw_clk = 1'b0;
        forever begin
            #2 iw_clk = ~iw_clk;
        end
    end

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_addr(input string what, input amber_pkg::addr_t got,
                              input amber_pkg::addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_data(input string what, input amber_pkg::data_t got,
                              input amber_pkg::data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    task automatic compare_outputs();
        check_addr("fetch_pc", fetch_pc, m_pc);
        check_bit("fetch_valid", fetch_valid, model_fetch_ok());
        check_bit("kernel_mode", kernel_mode, m_kernel);
        check_bit("csr_rd_valid", csr_rd_valid, m_rd_valid);
        if (m_rd_valid) begin
            check_data("csr_rd_data", csr_rd_data, m_rd_data);
            n_reads++;
        end
        if (!model_fetch_ok()) begin
            n_stalls++;
        end
        if (!m_kernel) begin
            n_user++;
        end
    endtask

    // Model steps on the edge, outputs settle, then the next input goes out
    task automatic run_cycle(input logic nv, input amber_pkg::instr_u ni);
        @(posedge iw_clk);
        model_edge(instr_valid, instr);
        #1;
        compare_outputs();
        instr_valid = nv;
        instr       = ni;
    endtask

    task automatic wait_for_read(input int limit);
        int n;
        n = 0;
        while (!csr_rd_valid) begin
            if (n == limit) begin
                abort_run("Timeout: the CSR read result never arrived");
            end else begin
                run_cycle(1'b0, '0);
                n++;
            end
        end
    endtask

    // ----------------------------------------
    // Random instruction stream
    // ----------------------------------------
    function automatic amber_pkg::instr_u make_random_instr();
        amber_pkg::instr_u w;
        logic [31:0]       r;
        logic [31:0]       s;
        r = lcg_next();
        s = lcg_next();
        w.csr.imm10 = s[15:6];
        case (s[27:24])
            4'd0:        w.csr.csr_idx = amber_pkg::CSR_STATUS;
            4'd1, 4'd10: w.csr.csr_idx = amber_pkg::CSR_PCC_BASE_LO;
            4'd2:        w.csr.csr_idx = amber_pkg::CSR_PCC_BASE_HI;
            4'd3, 4'd11: w.csr.csr_idx = amber_pkg::CSR_PCC_LEN_LO;
            4'd4:        w.csr.csr_idx = amber_pkg::CSR_PCC_LEN_HI;
            4'd5:        w.csr.csr_idx = amber_pkg::CSR_PCC_CUR_LO;
            4'd6:        w.csr.csr_idx = amber_pkg::CSR_PCC_CUR_HI;
            4'd7, 4'd12: w.csr.csr_idx = amber_pkg::CSR_PCC_PERMS;
            4'd8:        w.csr.csr_idx = amber_pkg::CSR_PCC_ATTR;
            4'd9, 4'd13: w.csr.csr_idx = amber_pkg::CSR_PCC_TAG;
            default:     w.csr.csr_idx = s[23:16];
        endcase
        // Upper halves mostly zero so the window stays reachable
        if ((w.csr.csr_idx == amber_pkg::CSR_PCC_BASE_HI ||
             w.csr.csr_idx == amber_pkg::CSR_PCC_LEN_HI) && s[31:30] != 2'b00) begin
            w.csr.imm10 = '0;
        end
        if (w.csr.csr_idx == amber_pkg::CSR_PCC_PERMS && s[29]) begin
            w.csr.imm10[2] = 1'b1;
        end
        case (r[31:28])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: w.csr.opcode = amber_pkg::OPC_CSRWR;
            4'd6, 4'd7, 4'd8, 4'd9:             w.csr.opcode = amber_pkg::OPC_CSRRD;
            4'd10, 4'd11:                       w.csr.opcode = amber_pkg::OPC_JUMP;
            4'd12:                              w.csr.opcode = amber_pkg::OPC_SYSCALL;
            4'd13:                              w.csr.opcode = amber_pkg::OPC_KRET;
            4'd14:                              w.csr.opcode = amber_pkg::OPC_NOP;
            default: w.csr.opcode = amber_pkg::opcode_e'(r[27:22]);
        endcase
        // Half the targets land near the low windows
        if ((w.jmp.opcode == amber_pkg::OPC_JUMP || w.jmp.opcode == amber_pkg::OPC_KRET)
            && s[28]) begin
            w.jmp.target = {8'd0, s[15:6]};
        end
        return w;
    endfunction

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        amber_pkg::instr_u w;
        logic [31:0]       r;
        iw_rst      = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        lcg_state   = 32'hc69c;
        n_reads     = 0;
        n_stalls    = 0;
        n_user      = 0;
        model_reset();
        repeat (2) @(posedge iw_clk);
        #1;
        iw_rst = 1'b0;
        compare_outputs();

        // Free run through the reset window
        for (int i = 0; i < 40; i++) begin
            run_cycle(1'b0, '0);
        end
        for (int i = 0; i < RAND_CYCLES; i++) begin
            r = lcg_next();
            run_cycle(r[31:30] != 2'b00, make_random_instr());
        end

        // Drain, then one STATUS read that must come back
        run_cycle(1'b0, '0);
        run_cycle(1'b0, '0);
        w             = '0;
        w.csr.opcode  = amber_pkg::OPC_CSRRD;
        w.csr.csr_idx = amber_pkg::CSR_STATUS;
        run_cycle(1'b1, w);
        wait_for_read(4);

        if (n_reads == 0 || n_stalls == 0 || n_user == 0) begin
            abort_run("Random stream missed reads, a stalled PC or user mode");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* amber_core_top.f */
+incdir+sim
design/amber_pkg.sv
design/fetch_gate.sv
design/instr_decode.sv
design/pcc_csr_window.sv
design/amber_core_top.sv
sim/amber_core_tb.sv

/* Makefile */
# Verilator build and run of the amber core testbench
# A $fatal in the testbench gives a non-zero exit status, so make fails

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module amber_core_tb \
		-f amber_core_top.f \
		-o amber_core_tb

run: compile
	./obj_dir/amber_core_tb

clean:
	rm -rf obj_dir
